//--- src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ---------------------------------------------------------------------------
// datapath and address widths
// ---------------------------------------------------------------------------
`define CPU_WORD_W      16
`define CPU_IADDR_W     8
`define CPU_DADDR_W     8

// instruction fields
`define CPU_OPCODE_W    5
`define CPU_REG_IDX_W   3
`define CPU_NUM_REGS    8

`endif

//--- src/cpu_isa_pkg.sv
`include "cpu_defines.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // ------------------------------------------------------------------------
    // opcode map, bits 15..11 of the instruction
    // ------------------------------------------------------------------------
    typedef enum logic [`CPU_OPCODE_W-1:0] {
        NOP  = 5'd0,  HALT = 5'd1,  LOAD = 5'd2,  STORE = 5'd3,
        LDIH = 5'd4,  ADD  = 5'd5,  ADDI = 5'd6,  SUB   = 5'd7,
        SUBI = 5'd8,  SUIH = 5'd9,  CMP  = 5'd10, AND   = 5'd11,
        OR   = 5'd12, XOR  = 5'd13, SLL  = 5'd14, SRL   = 5'd15,
        SET  = 5'd16, JUMP = 5'd17, JMPR = 5'd18, BZ    = 5'd19,
        BNZ  = 5'd20, BN   = 5'd21, BNN  = 5'd22, BC    = 5'd23,
        BNC  = 5'd24, LIOA = 5'd25, LIOB = 5'd26, LIOS  = 5'd27
    } op_e;

    // bubble loaded into every instruction register at reset
    localparam word_t NOP_WORD = {NOP, 11'd0};

    function automatic op_e op_of(word_t ir);
        return op_e'(ir[15:11]);
    endfunction

    function automatic reg_idx_t r1_of(word_t ir);
        return ir[10:8];
    endfunction

    function automatic reg_idx_t r2_of(word_t ir);
        return ir[6:4];
    endfunction

    function automatic reg_idx_t r3_of(word_t ir);
        return ir[2:0];
    endfunction

    // opcodes that write r1 in write-back
    function automatic logic is_reg_write(op_e op);
        return op inside {LOAD, LDIH, ADD, ADDI, SUB, SUBI, SUIH, AND, OR, XOR,
                          SLL, SRL, SET, LIOA, LIOB, LIOS};
    endfunction

endpackage

//--- src/cpu_core_pkg.sv
`include "cpu_defines.svh"

package cpu_core_pkg;

    typedef enum logic {IDLE, EXEC} run_state_e;

    // operand A comes from a register or is forced to zero
    typedef enum logic [1:0] {A_ZERO, A_R1, A_R2, A_HOLD} a_src_e;

    // operand B is an immediate field or r3
    typedef enum logic [2:0] {B_IMM4, B_IMM8, B_IMM8_HIGH, B_R3, B_HOLD} b_src_e;

    typedef logic [`CPU_IADDR_W-1:0] iaddr_t;
    typedef logic [`CPU_DADDR_W-1:0] daddr_t;

endpackage

//--- src/cpu_run_ctrl.sv
module cpu_run_ctrl
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  logic start,
    input  op_e  wb_op,
    output logic advance,
    output logic nxt
);

    run_state_e state;
    run_state_e state_nxt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // stop on halt in write-back or when enable drops
    always_comb
    begin
        state_nxt = state;
        nxt       = 1'b0;
        case (state)
            IDLE:
                if (enable && start)
                    state_nxt = EXEC;
            EXEC:
                if (!enable || (wb_op == HALT))
                begin
                    nxt       = 1'b1;
                    state_nxt = IDLE;
                end
            default:
                state_nxt = IDLE;
        endcase
    end

    assign advance = (state == EXEC);

endmodule

//--- src/cpu_fetch.sv
module cpu_fetch
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   advance,
    input  logic   branch_taken,
    input  iaddr_t branch_target,
    input  word_t  i_datain,
    output iaddr_t i_addr,
    output word_t  id_ir
);

    iaddr_t pc;

    assign i_addr = pc;

    // taken branch in memory overrides the sequential pc
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc    <= '0;
            id_ir <= NOP_WORD;
        end
        else if (advance)
        begin
            id_ir <= i_datain;
            if (branch_taken)
                pc <= branch_target;
            else
                pc <= pc + 1'b1;
        end
    end

endmodule

//--- src/cpu_regfile.sv
`include "cpu_defines.svh"

module cpu_regfile
    import cpu_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  reg_idx_t rd_a_idx,
    input  reg_idx_t rd_b_idx,
    input  reg_idx_t rd_s_idx,
    output word_t    rd_a,
    output word_t    rd_b,
    output word_t    rd_s,
    output word_t    gr1,
    output word_t    gr2,
    output word_t    gr3
);

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_idx] <= wr_data;
    end

    // no write-through, a write is seen the cycle after
    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];
    assign rd_s = regs[rd_s_idx];

    // io mirrors
    assign gr1 = regs[1];
    assign gr2 = regs[2];
    assign gr3 = regs[3];

endmodule

//--- src/cpu_decode.sv
module cpu_decode
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  word_t    id_ir,
    input  word_t    rd_a,
    input  word_t    rd_b,
    input  word_t    rd_s,
    output reg_idx_t rd_a_idx,
    output reg_idx_t rd_b_idx,
    output reg_idx_t rd_s_idx,
    output word_t    ex_ir,
    output word_t    op_a,
    output word_t    op_b,
    output word_t    store_data
);

    op_e    op;
    a_src_e a_src;
    b_src_e b_src;

    assign op = op_of(id_ir);

    // ------------------------------------------------------------------------
    // operand classification
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (op)
            JUMP:
                a_src = A_ZERO;
            LDIH, SUIH, ADDI, SUBI, SET, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                a_src = A_R1;
            LOAD, STORE, ADD, SUB, CMP, AND, OR, XOR, SLL, SRL:
                a_src = A_R2;
            default:
                a_src = A_HOLD;
        endcase

        case (op)
            LOAD, STORE, SLL, SRL:
                b_src = B_IMM4;
            ADDI, SUBI, SET, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                b_src = B_IMM8;
            LDIH, SUIH:
                b_src = B_IMM8_HIGH;
            ADD, SUB, CMP, AND, OR, XOR:
                b_src = B_R3;
            default:
                b_src = B_HOLD;
        endcase
    end

    // port a serves r1 or r2 and port s the store source
    assign rd_a_idx = (a_src == A_R1) ? r1_of(id_ir) : r2_of(id_ir);
    assign rd_b_idx = r3_of(id_ir);
    assign rd_s_idx = r1_of(id_ir);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_ir <= NOP_WORD;
        else if (advance)
            ex_ir <= id_ir;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            op_a       <= '0;
            op_b       <= '0;
            store_data <= '0;
        end
        else if (advance)
        begin
            case (a_src)
                A_ZERO: op_a <= '0;
                A_HOLD: op_a <= op_a;
                default: op_a <= rd_a;
            endcase
            case (b_src)
                B_IMM4:      op_b <= word_t'(id_ir[3:0]);
                B_IMM8:      op_b <= word_t'(id_ir[7:0]);
                B_IMM8_HIGH: op_b <= {id_ir[7:0], 8'h00};
                B_R3:        op_b <= rd_b;
                default:     op_b <= op_b;
            endcase
            if (op == STORE)
                store_data <= rd_s;
        end
    end

endmodule

//--- src/cpu_execute.sv
`include "cpu_defines.svh"

module cpu_execute
    import cpu_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  advance,
    input  word_t ex_ir,
    input  word_t op_a,
    input  word_t op_b,
    input  word_t store_data,
    input  word_t io_status,
    input  word_t io_datain_a,
    input  word_t io_datain_b,
    output word_t mem_ir,
    output word_t exec_result,
    output word_t mem_store_data,
    output logic  zf,
    output logic  nf,
    output logic  cf,
    output logic  mem_we
);

    op_e                   op;
    logic [`CPU_WORD_W:0]  alu_full;
    word_t                 ex_val;
    logic                  flag_en;

    assign op = op_of(ex_ir);

    // ------------------------------------------------------------------------
    // ALU with bit 16 as carry out or borrow
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (op)
            AND:                  alu_full = {1'b0, op_a & op_b};
            OR:                   alu_full = {1'b0, op_a | op_b};
            XOR:                  alu_full = {1'b0, op_a ^ op_b};
            SLL:                  alu_full = {cf, op_a << op_b[3:0]};
            SRL:                  alu_full = {cf, op_a >> op_b[3:0]};
            SET:                  alu_full = {1'b0, op_b};
            ADD, ADDI, LDIH:      alu_full = {1'b0, op_a} + {1'b0, op_b};
            SUB, SUBI, SUIH, CMP: alu_full = {1'b0, op_a} - {1'b0, op_b};
            // address and branch target arithmetic
            default:              alu_full = {cf, op_a + op_b};
        endcase
    end

    // io loads bypass the ALU
    always_comb
    begin
        case (op)
            LIOA:    ex_val = io_datain_a;
            LIOB:    ex_val = io_datain_b;
            LIOS:    ex_val = io_status;
            default: ex_val = alu_full[`CPU_WORD_W-1:0];
        endcase
    end

    assign flag_en = op inside {LDIH, SUIH, ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR,
                                SLL, SRL};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_ir <= NOP_WORD;
            mem_we <= 1'b0;
            zf     <= 1'b0;
            nf     <= 1'b0;
            cf     <= 1'b0;
        end
        else if (advance)
        begin
            mem_ir <= ex_ir;
            mem_we <= (op == STORE);
            if (flag_en)
            begin
                zf <= (alu_full[`CPU_WORD_W-1:0] == '0);
                nf <= alu_full[`CPU_WORD_W-1];
                cf <= alu_full[`CPU_WORD_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            exec_result    <= '0;
            mem_store_data <= '0;
        end
        else if (advance)
        begin
            exec_result <= ex_val;
            if (op == STORE)
                mem_store_data <= store_data;
        end
    end

endmodule

//--- src/cpu_mem_wb.sv
module cpu_mem_wb
    import cpu_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  logic     zf,
    input  logic     nf,
    input  logic     cf,
    input  word_t    mem_ir,
    input  word_t    exec_result,
    input  word_t    d_datain,
    output logic     branch_taken,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output op_e      wb_op
);

    op_e   mem_op;
    word_t wb_ir;
    word_t wb_data;

    assign mem_op = op_of(mem_ir);

    // flags are the ones left by the instruction just ahead
    always_comb
    begin
        case (mem_op)
            JUMP, JMPR: branch_taken = 1'b1;
            BZ:         branch_taken = zf;
            BNZ:        branch_taken = !zf;
            BN:         branch_taken = nf;
            BNN:        branch_taken = !nf;
            BC:         branch_taken = cf;
            BNC:        branch_taken = !cf;
            default:    branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wb_ir <= NOP_WORD;
        else if (advance)
            wb_ir <= mem_ir;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wb_data <= '0;
        else if (advance)
            wb_data <= (mem_op == LOAD) ? d_datain : exec_result;
    end

    // ------------------------------------------------------------------------
    // write-back
    // ------------------------------------------------------------------------
    assign wb_op   = op_of(wb_ir);
    assign wr_en   = advance && is_reg_write(wb_op);
    assign wr_idx  = r1_of(wb_ir);
    assign wr_data = wb_data;

endmodule

//--- src/pipe_cpu.sv
`include "cpu_defines.svh"

module pipe_cpu
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,
    input  logic   start,
    input  word_t  i_datain,
    input  word_t  d_datain,
    input  word_t  io_status,
    input  word_t  io_datain_a,
    input  word_t  io_datain_b,
    output logic   nxt,
    output logic   d_we,
    output iaddr_t i_addr,
    output daddr_t d_addr,
    output word_t  d_dataout,
    output word_t  io_control,
    output word_t  io_dataout_a,
    output word_t  io_dataout_b
);

    logic     advance;
    logic     branch_taken;
    iaddr_t   branch_target;
    op_e      wb_op;
    word_t    id_ir;
    word_t    ex_ir;
    word_t    mem_ir;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;
    word_t    exec_result;
    logic     zf;
    logic     nf;
    logic     cf;
    reg_idx_t rd_a_idx;
    reg_idx_t rd_b_idx;
    reg_idx_t rd_s_idx;
    word_t    rd_a;
    word_t    rd_b;
    word_t    rd_s;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    // ALU result doubles as jump target and data address
    assign branch_target = exec_result[`CPU_IADDR_W-1:0];
    assign d_addr        = exec_result[`CPU_DADDR_W-1:0];

    cpu_run_ctrl run_ctrl_i (
        .clk, .rst_n, .enable, .start, .wb_op, .advance, .nxt
    );

    cpu_fetch fetch_i (
        .clk, .rst_n, .advance, .branch_taken, .branch_target, .i_datain, .i_addr, .id_ir
    );

    cpu_decode decode_i (
        .clk, .rst_n, .advance, .id_ir, .rd_a, .rd_b, .rd_s,
        .rd_a_idx, .rd_b_idx, .rd_s_idx, .ex_ir, .op_a, .op_b, .store_data
    );

    cpu_regfile regfile_i (
        .clk, .rst_n, .wr_en, .wr_idx, .wr_data, .rd_a_idx, .rd_b_idx, .rd_s_idx,
        .rd_a, .rd_b, .rd_s,
        .gr1 (io_control),
        .gr2 (io_dataout_a),
        .gr3 (io_dataout_b)
    );

    cpu_execute execute_i (
        .clk, .rst_n, .advance, .ex_ir, .op_a, .op_b, .store_data,
        .io_status, .io_datain_a, .io_datain_b,
        .mem_ir, .exec_result,
        .mem_store_data (d_dataout),
        .zf, .nf, .cf,
        .mem_we         (d_we)
    );

    cpu_mem_wb mem_wb_i (
        .clk, .rst_n, .advance, .zf, .nf, .cf, .mem_ir, .exec_result, .d_datain,
        .branch_taken, .wr_en, .wr_idx, .wr_data, .wb_op
    );

endmodule

//--- sim/pipe_cpu_sva.sv
module pipe_cpu_sva
    import cpu_core_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input run_state_e state,
    input logic       advance,
    input logic       nxt
);

    timeunit 1ns;
    timeprecision 1ps;

    // stop pulse only while running
    nxt_only_in_exec: assert property (
        @(posedge clk) disable iff (!rst_n) nxt |-> state == EXEC)
        else $error("nxt high while the core is idle");

    // one stop pulse is enough to get back to idle
    idle_after_nxt: assert property (
        @(posedge clk) disable iff (!rst_n) nxt |=> state == IDLE)
        else $error("core not idle in the cycle after nxt");

    no_advance_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n) state == IDLE |-> !advance)
        else $error("pipeline advancing while idle");

endmodule

bind cpu_run_ctrl pipe_cpu_sva run_ctrl_sva_i (.clk, .rst_n, .state, .advance, .nxt);

//--- sim/pipe_cpu_tb.sv
`include "cpu_defines.svh"

module pipe_cpu_tb
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SLOTS  = 56;
    localparam int MEM_DEPTH  = 2 ** `CPU_IADDR_W;
    // 57 slots of four words plus pipeline fill and reset leave ample margin
    localparam int MAX_CYCLES = 400;

    logic   clk;
    logic   rst_n;
    logic   enable;
    logic   start;
    word_t  i_datain;
    word_t  d_datain;
    word_t  io_status;
    word_t  io_datain_a;
    word_t  io_datain_b;
    logic   nxt;
    logic   d_we;
    iaddr_t i_addr;
    daddr_t d_addr;
    word_t  d_dataout;
    word_t  io_control;
    word_t  io_dataout_a;
    word_t  io_dataout_b;

    word_t  imem [MEM_DEPTH];
    word_t  dmem [MEM_DEPTH];
    word_t  model_mem [MEM_DEPTH];
    word_t  model_regs [`CPU_NUM_REGS];
    logic   model_zf;
    logic   model_nf;
    logic   model_cf;
    daddr_t exp_addr [$];
    word_t  exp_data [$];

    integer seed;
    int     errors = 0;
    int     store_idx = 0;
    int     nxt_count = 0;
    int     cycles = 0;
    iaddr_t idle_addr;

    // combinational reads of the instruction and data memories
    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];

    pipe_cpu pipe_cpu_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp)
        begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_daddr(daddr_t got, daddr_t exp, string what);
        if (got !== exp)
        begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_iaddr(iaddr_t got, iaddr_t exp, string what);
        if (got !== exp)
        begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // random program of one instruction and three NOPs per slot
    // ------------------------------------------------------------------------
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        op_e         op;
        reg_idx_t    rd;
        int          i;
        int          j;
        for (i = 0; i < MEM_DEPTH; i++)
        begin
            imem[i]      = {NOP, 11'd0};
            dmem[i]      = $random(seed);
            model_mem[i] = dmem[i];
        end
        for (i = 0; i < NUM_SLOTS; i++)
        begin
            r  = $random(seed);
            s  = $random(seed);
            // about a quarter stores and the rest any opcode from LOAD up
            op = (r[31:30] == 2'b00) ? STORE : op_e'(2 + r[28:24] % 26);
            rd = (r[10:8] == 3'd0) ? 3'd1 : r[10:8];
            if (op inside {JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC})
            begin
                j = i + 1 + s[9:8] % 3;
                if (j > NUM_SLOTS)
                    j = NUM_SLOTS;
                imem[4 * i] = {op, 3'd0, iaddr_t'(4 * j)};
            end
            else if (op == STORE)
                imem[4 * i] = {op, r[10:8], s[7:0]};
            else
                imem[4 * i] = {op, rd, s[7:0]};
        end
        imem[4 * NUM_SLOTS] = {HALT, 11'd0};
    endtask

    // sequential instruction set model relying on NOP-only delay slots
    task automatic run_model();
        iaddr_t      pc;
        word_t       ir;
        op_e         op;
        word_t       a1;
        word_t       a2;
        word_t       a3;
        word_t       res;
        logic [16:0] full;
        logic        taken;
        logic        done;
        daddr_t      addr;
        iaddr_t      tgt;
        int          i;
        pc       = '0;
        done     = 1'b0;
        model_zf = 1'b0;
        model_nf = 1'b0;
        model_cf = 1'b0;
        for (i = 0; i < `CPU_NUM_REGS; i++)
            model_regs[i] = '0;
        while (!done)
        begin
            ir    = imem[pc];
            op    = op_e'(ir[15:11]);
            a1    = model_regs[ir[10:8]];
            a2    = model_regs[ir[6:4]];
            a3    = model_regs[ir[2:0]];
            addr  = daddr_t'(a2 + ir[3:0]);
            tgt   = iaddr_t'(a1 + ir[7:0]);
            full  = '0;
            res   = '0;
            taken = 1'b0;
            case (op)
                HALT:  done = 1'b1;
                LOAD:  res = model_mem[addr];
                STORE:
                begin
                    model_mem[addr] = a1;
                    exp_addr.push_back(addr);
                    exp_data.push_back(a1);
                end
                LDIH:  full = {1'b0, a1} + {1'b0, ir[7:0], 8'h00};
                ADD:   full = {1'b0, a2} + {1'b0, a3};
                ADDI:  full = {1'b0, a1} + {9'd0, ir[7:0]};
                SUB:   full = {1'b0, a2} - {1'b0, a3};
                SUBI:  full = {1'b0, a1} - {9'd0, ir[7:0]};
                SUIH:  full = {1'b0, a1} - {1'b0, ir[7:0], 8'h00};
                CMP:   full = {1'b0, a2} - {1'b0, a3};
                AND:   full = {1'b0, a2 & a3};
                OR:    full = {1'b0, a2 | a3};
                XOR:   full = {1'b0, a2 ^ a3};
                SLL:   full = {model_cf, a2 << ir[3:0]};
                SRL:   full = {model_cf, a2 >> ir[3:0]};
                SET:   res = word_t'(ir[7:0]);
                JUMP:
                begin
                    taken = 1'b1;
                    tgt   = ir[7:0];
                end
                JMPR:  taken = 1'b1;
                BZ:    taken = model_zf;
                BNZ:   taken = !model_zf;
                BN:    taken = model_nf;
                BNN:   taken = !model_nf;
                BC:    taken = model_cf;
                BNC:   taken = !model_cf;
                LIOA:  res = io_datain_a;
                LIOB:  res = io_datain_b;
                LIOS:  res = io_status;
                default: ;
            endcase
            if (op inside {LDIH, ADD, ADDI, SUB, SUBI, SUIH, CMP, AND, OR, XOR, SLL, SRL})
            begin
                res      = full[15:0];
                model_zf = (res == '0);
                model_nf = res[15];
                model_cf = full[16];
            end
            if (op inside {LOAD, LDIH, ADD, ADDI, SUB, SUBI, SUIH, AND, OR, XOR, SLL, SRL,
                           SET, LIOA, LIOB, LIOS})
                model_regs[ir[10:8]] = res;
            pc = taken ? tgt : pc + 1'b1;
        end
    endtask

    // ------------------------------------------------------------------------
    // store checker and data memory write port
    // ------------------------------------------------------------------------
    always @(posedge clk)
    begin
        if (rst_n && d_we)
        begin
            if (store_idx < exp_addr.size())
            begin
                check_daddr(d_addr, exp_addr[store_idx], "store address");
                check_word(d_dataout, exp_data[store_idx], "store data");
            end
            else
            begin
                $display("store to %h at %0d ns was not expected", d_addr, $time);
                errors++;
            end
            store_idx++;
            dmem[d_addr] <= d_dataout;
        end
        if (rst_n && nxt)
            nxt_count++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: core did not halt within %0d cycles, %0d errors so far",
                     MAX_CYCLES, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        seed        = 32'h328b12db;
        rst_n       = 1'b0;
        enable      = 1'b0;
        start       = 1'b0;
        io_status   = $random(seed);
        io_datain_a = $random(seed);
        io_datain_b = $random(seed);
        build_program();
        run_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // idle state out of reset
        check_bit(nxt, 1'b0, "nxt after reset");
        check_bit(d_we, 1'b0, "d_we after reset");
        check_iaddr(i_addr, '0, "i_addr after reset");
        check_word(io_control, '0, "io_control after reset");
        check_word(io_dataout_a, '0, "io_dataout_a after reset");
        check_word(io_dataout_b, '0, "io_dataout_b after reset");

        enable = 1'b1;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (nxt_count == 0)
            @(negedge clk);
        idle_addr = i_addr;
        repeat (5) @(negedge clk);

        check_iaddr(i_addr, idle_addr, "i_addr while idle");
        check_bit(nxt_count == 1, 1'b1, "single nxt pulse after halt");
        check_word(word_t'(store_idx), word_t'(exp_addr.size()), "store count");
        check_word(io_control, model_regs[1], "io_control at halt");
        check_word(io_dataout_a, model_regs[2], "io_dataout_a at halt");
        check_word(io_dataout_b, model_regs[3], "io_dataout_b at halt");

        $display("stores seen %0d of %0d, errors %0d", store_idx, exp_addr.size(), errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/cpu_isa_pkg.sv
src/cpu_core_pkg.sv
src/cpu_run_ctrl.sv
src/cpu_fetch.sv
src/cpu_regfile.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_mem_wb.sv
src/pipe_cpu.sv
sim/pipe_cpu_sva.sv
sim/pipe_cpu_tb.sv
